//--- hdl/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // basic widths
    typedef logic [31:0] word_t;        // data or byte address
    typedef logic [19:0] sram_addr_t;   // sram word address, addr[21:2]
    typedef logic [3:0]  be_n_t;        // byte enables, low active
    typedef logic [7:0]  uart_byte_t;   // one serial character
    typedef logic [2:0]  bit_idx_t;     // data bit position within a frame

    // one access from a core port
    typedef struct packed {
        word_t addr;
        word_t wdata;
        be_n_t be_n;
        logic  re;
        logic  we;
    } mem_req_t;

    // pins towards one async sram
    typedef struct packed {
        sram_addr_t addr;
        word_t      wdata;
        be_n_t      be_n;
        logic       ce_n;
        logic       oe_n;
        logic       we_n;
    } sram_bus_t;

    // shared by the serial tx and rx fsm
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

    // address map
    localparam word_t BASE_RAM_BASE   = 32'h8000_0000;  // 4 MB
    localparam word_t EXT_RAM_BASE    = 32'h8040_0000;  // 4 MB
    localparam word_t RAM_REGION_MASK = 32'hffc0_0000;  // 4 MB region select
    localparam word_t UART_DATA_ADDR  = 32'hbfd0_03f8;
    localparam word_t UART_STAT_ADDR  = 32'hbfd0_03fc;  // [0] tx idle, [1] rx avail

    // serial timing, kept short for simulation
    localparam int UART_CLKS_PER_BIT = 16;
    localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
    typedef logic [UART_CNT_W-1:0] baud_cnt_t;

endpackage

`default_nettype wire

//--- hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import soc_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       start_i,
    input  uart_byte_t data_i,
    output logic       txd_o,
    output logic       busy_o
);

    uart_state_e state_q;
    baud_cnt_t   baud_cnt_q;
    bit_idx_t    bit_idx_q;
    uart_byte_t  shift_q;     // next bit always at [0]
    logic        bit_end;

    assign bit_end = (baud_cnt_q == baud_cnt_t'(UART_CLKS_PER_BIT - 1));
    assign busy_o  = (state_q != IDLE);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            txd_o      <= 1'b1;                         // line idles high
        end else begin
            baud_cnt_q <= (state_q == IDLE || bit_end) ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                IDLE: if (start_i) begin
                    state_q <= START;
                    txd_o   <= 1'b0;                    // start bit
                end
                START: if (bit_end) begin
                    state_q <= DATA;
                    txd_o   <= shift_q[0];              // lsb first
                end
                DATA: if (bit_end) begin
                    bit_idx_q <= bit_idx_q + 1'b1;      // wraps back to 0 after bit 7
                    if (bit_idx_q == 3'd7) begin
                        state_q <= STOP;
                        txd_o   <= 1'b1;
                    end else begin
                        txd_o <= shift_q[0];
                    end
                end
                STOP: if (bit_end) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // payload shifter
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && start_i) begin
            shift_q <= data_i;
        end else if (bit_end && (state_q == START || state_q == DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

    // upstream must wait for idle before starting
    a_start_idle: assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !busy_o);

endmodule

`default_nettype wire

//--- hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import soc_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       rxd_i,
    output uart_byte_t data_o,
    output logic       valid_o
);

    uart_state_e state_q;
    baud_cnt_t   baud_cnt_q;
    bit_idx_t    bit_idx_q;
    uart_byte_t  shift_q;
    logic        rxd_meta;    // sync stage 1
    logic        rxd_sync;    // sync stage 2
    logic        rxd_prev;    // for edge detect
    logic        fall;
    logic        half_pt;
    logic        bit_end;

    assign fall    = rxd_prev & ~rxd_sync;
    assign half_pt = (baud_cnt_q == baud_cnt_t'(UART_CLKS_PER_BIT / 2 - 1));
    assign bit_end = (baud_cnt_q == baud_cnt_t'(UART_CLKS_PER_BIT - 1));
    assign data_o  = shift_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_meta   <= 1'b1;
            rxd_sync   <= 1'b1;
            rxd_prev   <= 1'b1;
            state_q    <= IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            valid_o    <= 1'b0;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            valid_o  <= 1'b0;                                // single-cycle pulse
            case (state_q)
                IDLE: begin
                    baud_cnt_q <= '0;
                    if (fall) state_q <= START;
                end
                START: if (half_pt) begin                    // middle of start bit
                    baud_cnt_q <= '0;                        // later samples land mid-bit
                    state_q    <= rxd_sync ? IDLE : DATA;    // glitch drops back
                end else begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end
                DATA: if (bit_end) begin
                    baud_cnt_q <= '0;
                    bit_idx_q  <= bit_idx_q + 1'b1;
                    if (bit_idx_q == 3'd7) state_q <= STOP;
                end else begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end
                STOP: if (bit_end) begin
                    baud_cnt_q <= '0;
                    state_q    <= IDLE;
                    valid_o    <= rxd_sync;                  // framing check
                end else begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk_i) begin
        if (state_q == DATA && bit_end) shift_q <= {rxd_sync, shift_q[7:1]};
    end

endmodule

`default_nettype wire

//--- hdl/uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl import soc_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       we_i,        // data register write
    input  logic       re_i,        // data register read
    input  uart_byte_t wdata_i,
    output logic       tx_idle_o,
    output logic       rx_avail_o,
    output uart_byte_t rx_data_o,
    output logic       txd_o,
    input  logic       rxd_i
);

    logic       tx_busy;
    logic       tx_start_q;
    uart_byte_t tx_data_q;
    logic       rx_valid;
    uart_byte_t rx_byte;

    uart_tx u_tx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (tx_start_q),
        .data_i  (tx_data_q),
        .txd_o   (txd_o),
        .busy_o  (tx_busy)
    );

    uart_rx u_rx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rxd_i   (rxd_i),
        .data_o  (rx_byte),
        .valid_o (rx_valid)
    );

    // pending start counts as busy so no second write slips in
    assign tx_idle_o = ~tx_busy & ~tx_start_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_start_q <= 1'b0;
            rx_avail_o <= 1'b0;
        end else begin
            tx_start_q <= we_i & tx_idle_o;
            if (rx_valid) rx_avail_o <= 1'b1;       // new byte beats a read clear
            else if (re_i) rx_avail_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (we_i && tx_idle_o) tx_data_q <= wdata_i;
        if (rx_valid) rx_data_o <= rx_byte;
    end

endmodule

`default_nettype wire

//--- hdl/mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge import soc_pkg::*; (
    // fetch port, request always active
    input  word_t      ifu_addr_i,
    output word_t      ifu_rdata_o,
    output logic       ifu_resp_o,
    // load/store port
    input  mem_req_t   lsu_req_i,
    output word_t      lsu_rdata_o,
    output logic       lsu_resp_o,
    // sram pins
    output sram_bus_t  base_ram_o,
    input  word_t      base_ram_rdata_i,
    output sram_bus_t  ext_ram_o,
    input  word_t      ext_ram_rdata_i,
    // uart controller side
    output logic       uart_we_o,
    output logic       uart_re_o,
    output uart_byte_t uart_wdata_o,
    input  logic       tx_idle_i,
    input  logic       rx_avail_i,
    input  uart_byte_t rx_data_i
);

    logic lsu_act;
    logic sel_base;
    logic sel_ext;
    logic sel_udata;
    logic sel_ustat;
    logic tx_hold;

    // pack one sram access into pin levels
    function automatic sram_bus_t sram_pins(word_t addr, word_t wdata, be_n_t be_n,
                                            logic cs, logic re, logic we);
        sram_bus_t pins;
        pins.addr  = addr[21:2];
        pins.wdata = wdata;
        pins.be_n  = be_n;
        pins.ce_n  = ~cs;
        pins.oe_n  = ~(cs & re);
        pins.we_n  = ~(cs & we);
        return pins;
    endfunction

    // lsu address decode
    assign lsu_act   = lsu_req_i.re | lsu_req_i.we;
    assign sel_base  = lsu_act && ((lsu_req_i.addr & RAM_REGION_MASK) == BASE_RAM_BASE);
    assign sel_ext   = lsu_act && ((lsu_req_i.addr & RAM_REGION_MASK) == EXT_RAM_BASE);
    assign sel_udata = lsu_act && (lsu_req_i.addr == UART_DATA_ADDR);
    assign sel_ustat = lsu_act && (lsu_req_i.addr == UART_STAT_ADDR);

    assign tx_hold    = sel_udata & lsu_req_i.we & ~tx_idle_i; // hold write until tx free
    assign lsu_resp_o = lsu_act & ~tx_hold;
    assign ifu_resp_o = ~sel_base;                             // lsu wins the base ram

    // base ram shared, fetch gets it whenever lsu is elsewhere
    assign base_ram_o = sel_base ?
        sram_pins(lsu_req_i.addr, lsu_req_i.wdata, lsu_req_i.be_n, 1'b1,
                  lsu_req_i.re, lsu_req_i.we) :
        sram_pins(ifu_addr_i, lsu_req_i.wdata, '0, 1'b1, 1'b1, 1'b0);

    assign ext_ram_o = sram_pins(lsu_req_i.addr, lsu_req_i.wdata, lsu_req_i.be_n,
                                 sel_ext, lsu_req_i.re, lsu_req_i.we);

    assign ifu_rdata_o = base_ram_rdata_i;

    // uart strobes only on responding accesses
    assign uart_we_o    = sel_udata & lsu_req_i.we & tx_idle_i;
    assign uart_re_o    = sel_udata & lsu_req_i.re & ~tx_hold;
    assign uart_wdata_o = lsu_req_i.wdata[7:0];

    // lsu read mux
    always_comb begin
        if (sel_base) begin
            lsu_rdata_o = base_ram_rdata_i;
        end else if (sel_ext) begin
            lsu_rdata_o = ext_ram_rdata_i;
        end else if (sel_udata) begin
            lsu_rdata_o = {24'd0, rx_data_i};
        end else if (sel_ustat) begin
            lsu_rdata_o = {30'd0, rx_avail_i, tx_idle_i};
        end else begin
            lsu_rdata_o = '0;                                  // unmapped reads zero
        end
    end

    // no clock here, checked once the comb settles
    always_comb begin
        assert final (ext_ram_o.ce_n || ifu_resp_o)
            else $error("lsu access selects both rams");
        assert final (!(uart_we_o || uart_re_o) || lsu_resp_o)
            else $error("uart strobe on an access without response");
    end

endmodule

`default_nettype wire

//--- hdl/soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  word_t     ifu_addr_i,
    output word_t     ifu_rdata_o,
    output logic      ifu_resp_o,
    input  mem_req_t  lsu_req_i,
    output word_t     lsu_rdata_o,
    output logic      lsu_resp_o,
    output sram_bus_t base_ram_o,
    output sram_bus_t ext_ram_o,
    input  word_t     base_ram_rdata_i,
    input  word_t     ext_ram_rdata_i,
    output logic      txd_o,
    input  logic      rxd_i
);

    logic       uart_we;     // one-cycle strobes from the bridge
    logic       uart_re;
    uart_byte_t uart_wdata;
    logic       tx_idle;
    logic       rx_avail;
    uart_byte_t rx_data;

    mem_bridge u_bridge (
        .ifu_addr_i       (ifu_addr_i),
        .ifu_rdata_o      (ifu_rdata_o),
        .ifu_resp_o       (ifu_resp_o),
        .lsu_req_i        (lsu_req_i),
        .lsu_rdata_o      (lsu_rdata_o),
        .lsu_resp_o       (lsu_resp_o),
        .base_ram_o       (base_ram_o),
        .base_ram_rdata_i (base_ram_rdata_i),
        .ext_ram_o        (ext_ram_o),
        .ext_ram_rdata_i  (ext_ram_rdata_i),
        .uart_we_o        (uart_we),
        .uart_re_o        (uart_re),
        .uart_wdata_o     (uart_wdata),
        .tx_idle_i        (tx_idle),
        .rx_avail_i       (rx_avail),
        .rx_data_i        (rx_data)
    );

    uart_ctrl u_uart (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .we_i       (uart_we),
        .re_i       (uart_re),
        .wdata_i    (uart_wdata),
        .tx_idle_o  (tx_idle),
        .rx_avail_o (rx_avail),
        .rx_data_o  (rx_data),
        .txd_o      (txd_o),
        .rxd_i      (rxd_i)
    );

endmodule

`default_nettype wire

//--- dv/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sram_model import soc_pkg::*; #(
    parameter logic [11:0] FILL_TAG = 12'h000    // top bits of the preload pattern
) (
    input  logic      clk_i,
    input  sram_bus_t ram_i,
    output word_t     rdata_o
);

    word_t mem [0:(1 << $bits(sram_addr_t)) - 1];

    // every word starts as tag plus its own word address
    initial begin
        for (int i = 0; i < (1 << $bits(sram_addr_t)); i++) begin
            mem[i] = {FILL_TAG, sram_addr_t'(i)};
        end
    end

    // async read, zero when not driven
    assign rdata_o = (!ram_i.ce_n && !ram_i.oe_n) ? mem[ram_i.addr] : '0;

    always @(posedge clk_i) begin
        if (!ram_i.ce_n && !ram_i.we_n) begin
            for (int b = 0; b < 4; b++) begin
                if (!ram_i.be_n[b]) mem[ram_i.addr][8*b +: 8] <= ram_i.wdata[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top import soc_pkg::*; ();

    localparam logic [11:0] BASE_TAG = 12'hb5e;
    localparam logic [11:0] EXT_TAG  = 12'he7a;
    localparam int TX_WAIT_LIMIT = 400;     // cycles, one frame is 160
    localparam int POLL_LIMIT    = 300;     // status polls, two cycles each
    localparam int MAX_OPS       = 32;

    typedef enum logic [2:0] {OP_RD, OP_WR, OP_FETCH, OP_LOOP, OP_PAIR} op_kind_e;

    typedef struct packed {
        op_kind_e kind;
        word_t    addr;
        word_t    wdata;
        be_n_t    be_n;
        word_t    exp;      // only for reads outside the rams
    } op_t;

    logic      clk_i;
    logic      rst_i;
    word_t     ifu_addr;
    word_t     ifu_rdata;
    logic      ifu_resp;
    mem_req_t  lsu_req;
    word_t     lsu_rdata;
    logic      lsu_resp;
    sram_bus_t base_ram;
    sram_bus_t ext_ram;
    word_t     base_rdata;
    word_t     ext_rdata;
    logic      txd;

    op_t       ops [MAX_OPS];
    string     op_name [MAX_OPS];
    int        n_ops;
    word_t     shadow_base [64];    // word offsets 0..63 of each region
    word_t     shadow_ext [64];
    integer    seed = 32'h9e6764fd;

    soc_top UUT (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .ifu_addr_i       (ifu_addr),
        .ifu_rdata_o      (ifu_rdata),
        .ifu_resp_o       (ifu_resp),
        .lsu_req_i        (lsu_req),
        .lsu_rdata_o      (lsu_rdata),
        .lsu_resp_o       (lsu_resp),
        .base_ram_o       (base_ram),
        .ext_ram_o        (ext_ram),
        .base_ram_rdata_i (base_rdata),
        .ext_ram_rdata_i  (ext_rdata),
        .txd_o            (txd),
        .rxd_i            (txd)          // serial loopback
    );

    sram_model #(.FILL_TAG(BASE_TAG)) u_base_ram (
        .clk_i   (clk_i),
        .ram_i   (base_ram),
        .rdata_o (base_rdata)
    );

    sram_model #(.FILL_TAG(EXT_TAG)) u_ext_ram (
        .clk_i   (clk_i),
        .ram_i   (ext_ram),
        .rdata_o (ext_rdata)
    );

    always #10 clk_i = ~clk_i;

    function automatic mem_req_t make_req(word_t addr, word_t wdata, be_n_t be_n,
                                          logic re, logic we);
        mem_req_t r;
        r.addr  = addr;
        r.wdata = wdata;
        r.be_n  = be_n;
        r.re    = re;
        r.we    = we;
        return r;
    endfunction

    function automatic logic in_region(word_t addr, word_t base);
        return (addr & RAM_REGION_MASK) == base;
    endfunction

    // low bytes of be_n pick new data
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_n_t be_n);
        word_t m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (!be_n[b]) m[8*b +: 8] = new_w[8*b +: 8];
        end
        return m;
    endfunction

    function automatic word_t expect_read(op_t op);
        if (in_region(op.addr, BASE_RAM_BASE)) return shadow_base[op.addr[7:2]];
        if (in_region(op.addr, EXT_RAM_BASE)) return shadow_ext[op.addr[7:2]];
        return op.exp;
    endfunction

    task automatic add_op(string name, op_kind_e kind, word_t addr, word_t wdata,
                          be_n_t be_n, word_t exp);
        op_name[n_ops]    = name;
        ops[n_ops].kind   = kind;
        ops[n_ops].addr   = addr;
        ops[n_ops].wdata  = wdata;
        ops[n_ops].be_n   = be_n;
        ops[n_ops].exp    = exp;
        n_ops++;
    endtask

    task automatic shadow_write(word_t addr, word_t wdata, be_n_t be_n);
        if (in_region(addr, BASE_RAM_BASE)) begin
            shadow_base[addr[7:2]] = merge_bytes(shadow_base[addr[7:2]], wdata, be_n);
        end else if (in_region(addr, EXT_RAM_BASE)) begin
            shadow_ext[addr[7:2]] = merge_bytes(shadow_ext[addr[7:2]], wdata, be_n);
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) abort_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    endtask

    // one lsu cycle, sampled mid-cycle, port idle again afterwards
    task automatic lsu_access(input mem_req_t req, output word_t rdata,
                              output logic resp, output logic fresp);
        @(posedge clk_i);
        lsu_req <= req;
        @(negedge clk_i);
        rdata = lsu_rdata;
        resp  = lsu_resp;
        fresp = ifu_resp;
        @(posedge clk_i);
        lsu_req <= make_req('0, '0, '1, 1'b0, 1'b0);
    endtask

    task automatic fetch_check(string name, word_t addr);
        @(posedge clk_i);
        ifu_addr <= addr;
        @(negedge clk_i);
        check_flag({name, "_ifu_resp"}, 1'b1, ifu_resp);
        check_word(name, shadow_base[addr[7:2]], ifu_rdata);
    endtask

    // hold the data write until the bridge takes it
    task automatic uart_send(string name, uart_byte_t b, logic expect_hold);
        int waited;
        waited = 0;
        @(posedge clk_i);
        lsu_req <= make_req(UART_DATA_ADDR, {24'd0, b}, '0, 1'b0, 1'b1);
        @(negedge clk_i);
        check_flag({name, "_first_resp"}, ~expect_hold, lsu_resp);
        while (!lsu_resp && waited < TX_WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!lsu_resp) abort_run({"transmitter never went idle during ", name});
        @(posedge clk_i);
        lsu_req <= make_req('0, '0, '1, 1'b0, 1'b0);
    endtask

    task automatic uart_receive(string name, uart_byte_t b);
        word_t rdata;
        logic  resp;
        logic  fresp;
        int    polls;
        polls = 0;
        rdata = '0;
        while (!rdata[1] && polls < POLL_LIMIT) begin
            lsu_access(make_req(UART_STAT_ADDR, '0, '0, 1'b1, 1'b0), rdata, resp, fresp);
            polls++;
        end
        if (!rdata[1]) abort_run({"no received byte showed up for ", name});
        lsu_access(make_req(UART_DATA_ADDR, '0, '0, 1'b1, 1'b0), rdata, resp, fresp);
        check_flag({name, "_rd_resp"}, 1'b1, resp);
        check_word({name, "_rx_byte"}, {24'd0, b}, rdata);
        lsu_access(make_req(UART_STAT_ADDR, '0, '0, 1'b1, 1'b0), rdata, resp, fresp);
        check_flag({name, "_avail_clr"}, 1'b0, rdata[1]);
    endtask

    task automatic uart_pair(string name);
        uart_byte_t a;
        uart_byte_t b;
        a = uart_byte_t'($random(seed));
        b = uart_byte_t'($random(seed));
        uart_send({name, "_a"}, a, 1'b0);
        uart_send({name, "_b"}, b, 1'b1);       // first frame still on the wire
        uart_receive({name, "_a"}, a);
        uart_receive({name, "_b"}, b);
    endtask

    task automatic build_table();
        add_op("stat_reset",  OP_RD,    UART_STAT_ADDR, '0, '0, 32'h1);
        add_op("ext_wr_full", OP_WR,    EXT_RAM_BASE + 32'h10, $random(seed), 4'b0000, '0);
        add_op("ext_wr_lo",   OP_WR,    EXT_RAM_BASE + 32'h10, $random(seed), 4'b1100, '0);
        add_op("ext_rd_lo",   OP_RD,    EXT_RAM_BASE + 32'h10, '0, '0, '0);
        add_op("ext_wr_b2",   OP_WR,    EXT_RAM_BASE + 32'h24, $random(seed), 4'b1011, '0);
        add_op("ext_rd_b2",   OP_RD,    EXT_RAM_BASE + 32'h24, '0, '0, '0);
        add_op("ext_wr_b13",  OP_WR,    EXT_RAM_BASE + 32'h24, $random(seed), 4'b0101, '0);
        add_op("ext_rd_b13",  OP_RD,    EXT_RAM_BASE + 32'h24, '0, '0, '0);
        add_op("fetch_pre",   OP_FETCH, BASE_RAM_BASE + 32'h08, '0, '0, '0);
        add_op("base_wr",     OP_WR,    BASE_RAM_BASE + 32'h08, $random(seed), 4'b0000, '0);
        add_op("fetch_new",   OP_FETCH, BASE_RAM_BASE + 32'h08, '0, '0, '0);
        add_op("uart_loop",   OP_LOOP,  UART_DATA_ADDR, '0, '0, '0);
        add_op("uart_pair",   OP_PAIR,  UART_DATA_ADDR, '0, '0, '0);
        add_op("unmap_wr",    OP_WR,    32'h1000_0000, $random(seed), 4'b0000, '0);
        add_op("unmap_rd",    OP_RD,    32'h1000_0000, '0, '0, 32'h0);
        add_op("stat_end",    OP_RD,    UART_STAT_ADDR, '0, '0, 32'h1);
    endtask

    initial begin
        word_t rdata;
        logic  resp;
        logic  fresp;
        clk_i    = 1'b0;
        rst_i    = 1'b1;
        ifu_addr = BASE_RAM_BASE;
        lsu_req  = make_req('0, '0, '1, 1'b0, 1'b0);
        n_ops    = 0;
        for (int i = 0; i < 64; i++) begin
            shadow_base[i] = {BASE_TAG, sram_addr_t'(i)};
            shadow_ext[i]  = {EXT_TAG, sram_addr_t'(i)};
        end
        build_table();
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_flag("txd_idle", 1'b1, txd);

        for (int i = 0; i < n_ops; i++) begin
            case (ops[i].kind)
                OP_RD: begin
                    lsu_access(make_req(ops[i].addr, '0, '0, 1'b1, 1'b0), rdata, resp, fresp);
                    check_flag({op_name[i], "_resp"}, 1'b1, resp);
                    check_word(op_name[i], expect_read(ops[i]), rdata);
                end
                OP_WR: begin
                    lsu_access(make_req(ops[i].addr, ops[i].wdata, ops[i].be_n, 1'b0, 1'b1),
                               rdata, resp, fresp);
                    check_flag({op_name[i], "_resp"}, 1'b1, resp);
                    if (in_region(ops[i].addr, BASE_RAM_BASE)) begin
                        check_flag({op_name[i], "_ifu_stall"}, 1'b0, fresp);  // lsu owns base ram
                    end
                    shadow_write(ops[i].addr, ops[i].wdata, ops[i].be_n);
                end
                OP_FETCH: fetch_check(op_name[i], ops[i].addr);
                OP_LOOP: begin
                    uart_byte_t b;
                    b = uart_byte_t'($random(seed));
                    uart_send(op_name[i], b, 1'b0);
                    uart_receive(op_name[i], b);
                end
                OP_PAIR: uart_pair(op_name[i]);
                default: abort_run("unknown operation kind in stimulus table");
            endcase
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/soc_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_ctrl.sv
hdl/mem_bridge.sv
hdl/soc_top.sv
dv/sram_model.sv
dv/tb_soc_top.sv
